//--- vlog.f
+incdir+sim
common/afu_chk_pkg.sv
protocol_checker/tlp_rule_checker.sv
protocol_checker/error_log.sv
rtl/tx_hdr_decoder.sv
rtl/tx_traffic_gate.sv
rtl/afu_tx_checker_top.sv
sim/tb_afu_tx_checker.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the AFU TX checker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --timescale 1ns/10ps \
   -f vlog.f --top-module tb_afu_tx_checker -o tb_afu_tx_checker

out=$(./obj_dir/tb_afu_tx_checker)
echo "$out"

if grep -qx "Testbench passed" <<< "$out"; then
   exit 0
fi
exit 1

//--- sim/tlp_model.svh
// Testbench model: packet kinds, random packet builder, expected errors and host beat queue
`ifndef TLP_MODEL_SVH
`define TLP_MODEL_SVH

localparam int KIND_LEGAL   = 0;
localparam int KIND_MALFORM = 1;
localparam int KIND_PAYLOAD = 2;
localparam int KIND_RD_REQ  = 3;
localparam int KIND_TAG     = 4;
localparam int MAX_BEATS    = 4;

tlp_flit_t exp_q[$];          // Beats the host should see, in order
tlp_flit_t pkt_q[$];          // Packet being sent
tlp_hdr_t  pkt_hdr;
err_vec_t  exp_vec = '0;      // Predicted sticky vector
tlp_hdr_t  exp_hdr = '0;      // Predicted first-error header

// Errors one header should raise
function automatic err_vec_t predict_err(input tlp_hdr_t h);
   err_vec_t e;
   e = '0;
   case (h.fmt_type)
      FMT_MRD: begin
         e.max_rd_req = (h.length > MAX_RD_REQ_BYTES);
         e.max_tag    = (h.tag >= MAX_TAGS);
      end
      FMT_MWR:  e.max_payload = (h.length > MAX_PLD_BYTES);
      FMT_CPLD: e = '0;                 // No limits on completions
      default:  e.malformed = 1'b1;
   endcase
   if (h.length == '0)
      e.malformed = 1'b1;
   return e;
endfunction

// The one bit a violating packet of this kind sets
function automatic err_vec_t kind_bit(input int kind);
   err_vec_t e;
   e = '0;
   case (kind)
      KIND_MALFORM: e.malformed   = 1'b1;
      KIND_PAYLOAD: e.max_payload = 1'b1;
      KIND_RD_REQ:  e.max_rd_req  = 1'b1;
      KIND_TAG:     e.max_tag     = 1'b1;
      default:      e = '0;
   endcase
   return e;
endfunction

function automatic tlp_hdr_t make_hdr(input int kind);
   tlp_hdr_t h;
   h          = '0;
   h.fmt_type = FMT_MRD;
   h.tag      = TAG_W'($urandom_range(0, 95));
   h.addr     = {$urandom, $urandom};
   case (kind)
      KIND_MALFORM: begin
         if ($urandom % 2 == 0) begin
            h.fmt_type = 8'($urandom);   // Unknown type, any length
            while (h.fmt_type == FMT_MRD || h.fmt_type == FMT_MWR ||
                   h.fmt_type == FMT_CPLD)
               h.fmt_type = 8'($urandom);
            h.length = LEN_W'($urandom_range(0, 2048));
         end else begin
            h.fmt_type = ($urandom % 2 == 0) ? FMT_MWR : FMT_MRD;
            h.length   = '0;
         end
      end
      KIND_PAYLOAD: begin
         h.fmt_type = FMT_MWR;
         h.length   = LEN_W'($urandom_range(513, 4096));
      end
      KIND_RD_REQ: h.length = LEN_W'($urandom_range(1025, 8192));
      KIND_TAG: begin
         h.length = LEN_W'($urandom_range(1, 1024));
         h.tag    = TAG_W'($urandom_range(96, 1023));
      end
      default: begin
         case ($urandom % 3)
            0: h.length = LEN_W'($urandom_range(1, 1024));
            1: begin
               h.fmt_type = FMT_MWR;
               h.length   = LEN_W'($urandom_range(1, 512));
               h.tag      = TAG_W'($urandom);      // Tag unchecked on writes
            end
            default: begin
               h.fmt_type = FMT_CPLD;
               h.length   = LEN_W'($urandom_range(1, 4096));
               h.tag      = TAG_W'($urandom);
            end
         endcase
      end
   endcase
   return h;
endfunction

// Fill pkt_q with one packet, random length unless nbeats is given
function automatic void build_packet(input int kind, input int nbeats);
   tlp_flit_t f;
   int        n;
   n       = (nbeats > 0) ? nbeats : int'($urandom_range(1, MAX_BEATS));
   pkt_hdr = make_hdr(kind);
   pkt_q.delete();
   for (int b = 0; b < n; b++) begin
      for (int w = 0; w < DATA_W / 32; w++)
         f.data[w*32 +: 32] = $urandom;
      if (b == 0)
         f.data[HDR_W-1:0] = pkt_hdr;   // Header overlay on the SOP beat
      f.keep = KEEP_W'($urandom);
      f.last = (b == n - 1);
      pkt_q.push_back(f);
   end
endfunction

// Log the packet's errors, queue its beats while nothing is frozen
function automatic void model_packet();
   err_vec_t e;
   e = predict_err(pkt_hdr);
   if (exp_vec == '0 && e != '0)
      exp_hdr = pkt_hdr;
   exp_vec = exp_vec | e;
   if (exp_vec == '0) begin
      foreach (pkt_q[i])
         exp_q.push_back(pkt_q[i]);
   end
endfunction

`endif

//--- sim/tb_afu_tx_checker.sv
// Testbench for the AFU TX checker: clock, reset, host ready, stimulus, monitor and tests
`timescale 1ns/10ps

module tb_afu_tx_checker
   import afu_chk_pkg::*;
();

   localparam int N_LEGAL     = 40;
   localparam int N_ERR_PKT   = 6;     // Two legal, the bad one, three legal
   localparam int N_BP        = 60;
   localparam int N_CLR       = 20;
   localparam int TOTAL_PKTS  = N_LEGAL + 1 + 4 * N_ERR_PKT + N_BP + 1 + N_CLR;
   localparam int DRAIN_LIMIT = 2000;

   logic      clk;
   logic      rst_n;
   logic      i_afu_tx_valid;
   tlp_flit_t i_afu_tx;
   logic      o_afu_tx_ready;
   logic      o_host_tx_valid;
   tlp_flit_t o_host_tx;
   logic      i_host_tx_ready;
   logic      i_clear_errors;
   err_vec_t  o_error_vector;
   tlp_hdr_t  o_error_hdr;
   logic      o_blocking;

   bit        ready_random;   // Random host back-pressure
   int        errors;
   int        test_errors;
   int        checks;
   int        tests_run;
   int        tests_failed;
   string     kind_name [5] = '{"legal", "malformed", "max_payload", "max_rd_req", "max_tag"};

   `include "tlp_model.svh"

   localparam int WATCHDOG_CYCLES = TOTAL_PKTS * MAX_BEATS * 40;

   afu_tx_checker_top i_dut (
      .clk             (clk),
      .rst_n           (rst_n),
      .i_afu_tx_valid  (i_afu_tx_valid),
      .i_afu_tx        (i_afu_tx),
      .o_afu_tx_ready  (o_afu_tx_ready),
      .o_host_tx_valid (o_host_tx_valid),
      .o_host_tx       (o_host_tx),
      .i_host_tx_ready (i_host_tx_ready),
      .i_clear_errors  (i_clear_errors),
      .o_error_vector  (o_error_vector),
      .o_error_hdr     (o_error_hdr),
      .o_blocking      (o_blocking)
   );

   // ##############################
   // Check and stimulus helpers
   // ##############################
   task automatic note_error();
      errors++;
      test_errors++;
   endtask

   task automatic check_val(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
         note_error();
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic drive_packet(input int kind);
      int gap;
      build_packet(kind, 0);
      model_packet();
      foreach (pkt_q[b]) begin
         gap = $urandom % 3;
         if (gap > 0) begin
            i_afu_tx_valid = 1'b0;
            idle_cycles(gap);
         end
         i_afu_tx_valid = 1'b1;
         i_afu_tx       = pkt_q[b];
         @(posedge clk);
         while (!o_afu_tx_ready)
            @(posedge clk);
         #2;
      end
      i_afu_tx_valid = 1'b0;
   endtask

   // Wait for the expected beats, then flush both stages with ready high
   task automatic drain(input string what);
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
         idle_cycles(1);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("%0d beats never reached the host during %s", exp_q.size(), what);
         note_error();
         exp_q.delete();
      end
      ready_random = 1'b0;
      idle_cycles(4);
   endtask

   task automatic pulse_clear();
      i_clear_errors = 1'b1;
      idle_cycles(1);
      i_clear_errors = 1'b0;
      exp_vec        = '0;
      idle_cycles(1);
   endtask

   task automatic check_status();
      check_val("o_error_vector", DATA_W'(o_error_vector), DATA_W'(exp_vec));
      check_val("o_blocking", DATA_W'(o_blocking), DATA_W'(exp_vec != '0));
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (test_errors != 0)
         tests_failed++;
      $display("Test %0d %s: %s, %0d errors", tests_run, name,
               (test_errors == 0) ? "ok" : "FAILED", test_errors);
      test_errors = 0;
   endtask

   // ##############################
   // Clock, host ready, monitor
   // ##############################
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin : host_ready_drive
      bit          mode_now;
      int unsigned draw;
      i_host_tx_ready = 1'b1;
      forever begin
         @(posedge clk);
         mode_now = ready_random;
         draw     = $urandom % 4;      // Ready about three cycles in four
         #2;
         i_host_tx_ready = mode_now ? (draw != 0) : 1'b1;
      end
   end

   always @(negedge clk) begin : host_monitor
      tlp_flit_t exp_beat;
      if (rst_n) begin
         check_val("o_afu_tx_ready", DATA_W'(o_afu_tx_ready), DATA_W'(i_host_tx_ready));
         if (o_host_tx_valid && i_host_tx_ready) begin
            if (exp_q.size() == 0) begin
               $display("A beat reached the host although none was expected");
               note_error();
            end else begin
               exp_beat = exp_q.pop_front();
               check_val("o_host_tx.data", o_host_tx.data, exp_beat.data);
               check_val("o_host_tx.keep", DATA_W'(o_host_tx.keep), DATA_W'(exp_beat.keep));
               check_val("o_host_tx.last", DATA_W'(o_host_tx.last), DATA_W'(exp_beat.last));
            end
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      $display("Testbench failed");
      $finish;
   end

   // ##############################
   // Tests
   // ##############################
   initial begin : stimulus
      int k;
      int lat;
      void'($urandom(79253));
      rst_n          = 1'b0;
      i_afu_tx_valid = 1'b0;
      i_afu_tx       = '0;
      i_clear_errors = 1'b0;
      ready_random   = 1'b0;
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;

      for (k = 0; k < N_LEGAL; k++)
         drive_packet(KIND_LEGAL);
      drain("legal traffic");
      check_status();
      end_test("legal traffic");

      // Two register stages from presenting a beat to the host port
      build_packet(KIND_LEGAL, 1);
      model_packet();
      i_afu_tx_valid = 1'b1;
      i_afu_tx       = pkt_q[0];
      idle_cycles(1);
      i_afu_tx_valid = 1'b0;
      lat = 1;
      while (!o_host_tx_valid && lat < 8) begin
         idle_cycles(1);
         lat++;
      end
      check_val("o_host_tx_valid latency", DATA_W'(lat), DATA_W'(2));
      drain("latency");
      end_test("latency");

      for (k = KIND_MALFORM; k <= KIND_TAG; k++) begin
         ready_random = 1'b1;
         drive_packet(KIND_LEGAL);
         drive_packet(KIND_LEGAL);
         drive_packet(k);
         repeat (3) drive_packet(KIND_LEGAL);   // Must all be dropped
         drain(kind_name[k]);
         check_val("o_error_vector", DATA_W'(o_error_vector), DATA_W'(kind_bit(k)));
         check_val("o_error_hdr", DATA_W'(o_error_hdr), DATA_W'(exp_hdr));
         check_val("o_blocking", DATA_W'(o_blocking), DATA_W'(1'b1));
         pulse_clear();
         check_status();
         end_test(kind_name[k]);
      end

      ready_random = 1'b1;
      for (k = 0; k < N_BP; k++)
         drive_packet(KIND_LEGAL);
      drain("back-pressure");
      check_status();
      end_test("back-pressure");

      ready_random = 1'b1;
      drive_packet(KIND_TAG);
      drain("clear setup");
      check_val("o_blocking", DATA_W'(o_blocking), DATA_W'(1'b1));
      pulse_clear();
      check_status();
      ready_random = 1'b1;
      for (k = 0; k < N_CLR; k++)
         drive_packet(KIND_LEGAL);
      drain("clear");
      check_status();
      end_test("clear");

      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

//--- rtl/afu_tx_checker_top.sv
// Top level of the AFU TX protocol checker: decoder, rule checker, error log, gate
`timescale 1ns/10ps

module afu_tx_checker_top
   import afu_chk_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,

   // From the AFU
   input  logic      i_afu_tx_valid,
   input  tlp_flit_t i_afu_tx,
   output logic      o_afu_tx_ready,

   // To the host
   output logic      o_host_tx_valid,
   output tlp_flit_t o_host_tx,
   input  logic      i_host_tx_ready,

   // Error status
   input  logic      i_clear_errors,
   output err_vec_t  o_error_vector,
   output tlp_hdr_t  o_error_hdr,
   output logic      o_blocking
);

   logic      s1_valid;
   logic      s1_sop;
   tlp_flit_t s1_flit;
   hdr_info_t s1_hdr;
   err_vec_t  s1_err;

   // Both stages share the host ready as enable
   assign o_afu_tx_ready = i_host_tx_ready;

   // ##############################
   // Input side
   // ##############################
   tx_hdr_decoder u_decoder (
      .clk     (clk),
      .rst_n   (rst_n),
      .i_valid (i_afu_tx_valid),
      .i_flit  (i_afu_tx),
      .i_ready (i_host_tx_ready),
      .o_valid (s1_valid),
      .o_sop   (s1_sop),
      .o_flit  (s1_flit),
      .o_hdr   (s1_hdr)
   );

   // ##############################
   // Checks and error log
   // ##############################
   tlp_rule_checker u_checker (
      .i_hdr (s1_hdr),
      .o_err (s1_err)
   );

   error_log u_error_log (
      .clk            (clk),
      .rst_n          (rst_n),
      .i_en           (i_host_tx_ready),
      .i_sop_valid    (s1_valid & s1_sop),
      .i_err          (s1_err),
      .i_hdr_raw      (s1_flit.data[HDR_W-1:0]),
      .i_clear_errors (i_clear_errors),
      .o_error_vector (o_error_vector),
      .o_error_hdr    (o_error_hdr),
      .o_blocking     (o_blocking)
   );

   // Output side
   tx_traffic_gate u_gate (
      .clk        (clk),
      .rst_n      (rst_n),
      .i_valid    (s1_valid),
      .i_flit     (s1_flit),
      .i_ready    (i_host_tx_ready),
      .i_blocking (o_blocking),
      .o_valid    (o_host_tx_valid),
      .o_flit     (o_host_tx)
   );

endmodule

//--- rtl/tx_traffic_gate.sv
// Stage-2 output register that drops beats while traffic is blocked
`timescale 1ns/10ps

module tx_traffic_gate
   import afu_chk_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,

   input  logic      i_valid,
   input  tlp_flit_t i_flit,
   input  logic      i_ready,      // Host ready, shared enable
   input  logic      i_blocking,

   output logic      o_valid,
   output tlp_flit_t o_flit
);

   logic pass;   // Beat entering stage 2 goes to the host

   assign pass = i_valid & ~i_blocking;

   // ##############################
   // Stage 2 control
   // ##############################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_valid <= 1'b0;
      end else if (i_ready) begin
         o_valid <= pass;   // A dropped beat stays dropped
      end
   end

   // Stage 2 payload
   always_ff @(posedge clk) begin
      if (i_ready) begin
         o_flit <= i_flit;
      end
   end

endmodule

//--- rtl/tx_hdr_decoder.sv
// TX header decoder with SOP/EOP tracking and the stage-1 pipeline register
`timescale 1ns/10ps

module tx_hdr_decoder
   import afu_chk_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,

   input  logic      i_valid,
   input  tlp_flit_t i_flit,
   input  logic      i_ready,    // Shared pipeline enable

   output logic      o_valid,
   output logic      o_sop,
   output tlp_flit_t o_flit,
   output hdr_info_t o_hdr
);

   logic      xfer;          // Beat accepted this cycle
   logic      sop_now;
   logic      trans_in_prog; // Between SOP and EOP
   tlp_hdr_t  raw_hdr;
   hdr_info_t dec_hdr;

   assign xfer    = i_valid & i_ready;
   assign sop_now = i_valid & ~trans_in_prog;

   // ##############################
   // Packet boundary tracking
   // ##############################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         trans_in_prog <= 1'b0;   // First beat after reset is an SOP
      end else if (xfer) begin
         trans_in_prog <= ~i_flit.last;
      end
   end

   // ##############################
   // Header decode
   // ##############################
   assign raw_hdr = i_flit.data[HDR_W-1:0];

   always_comb begin
      dec_hdr         = '0;
      dec_hdr.is_rd   = (raw_hdr.fmt_type == FMT_MRD);
      dec_hdr.is_wr   = (raw_hdr.fmt_type == FMT_MWR);
      dec_hdr.is_cpl  = (raw_hdr.fmt_type == FMT_CPLD);
      dec_hdr.type_ok = dec_hdr.is_rd | dec_hdr.is_wr | dec_hdr.is_cpl;
      dec_hdr.length  = raw_hdr.length;
      dec_hdr.tag     = raw_hdr.tag;
   end

   // Stage 1 control
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_valid <= 1'b0;
         o_sop   <= 1'b0;
      end else if (i_ready) begin
         o_valid <= i_valid;
         o_sop   <= sop_now;   // Only high together with valid
      end
   end

   // Stage 1 payload, held while stalled
   always_ff @(posedge clk) begin
      if (i_ready) begin
         o_flit <= i_flit;
         o_hdr  <= dec_hdr;    // Meaningful only on SOP beats
      end
   end

endmodule

//--- protocol_checker/error_log.sv
// Sticky error vector, first-error header capture and the traffic blocking flag
`timescale 1ns/10ps

module error_log
   import afu_chk_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,

   input  logic     i_en,            // Pipeline advances this cycle
   input  logic     i_sop_valid,     // Stage 1 holds a valid SOP
   input  err_vec_t i_err,
   input  tlp_hdr_t i_hdr_raw,
   input  logic     i_clear_errors,

   output err_vec_t o_error_vector,
   output tlp_hdr_t o_error_hdr,
   output logic     o_blocking
);

   err_vec_t new_err;     // Errors of the SOP leaving stage 1
   logic     new_hit;
   logic     frozen;      // Some sticky bit already set

   // Checker result only counts for an SOP that moves on this edge
   assign new_err = (i_en & i_sop_valid) ? i_err : '0;
   assign new_hit = |new_err;
   assign frozen  = |o_error_vector;

   // Includes a hit now so the gate drops the SOP on its own load edge
   assign o_blocking = frozen | new_hit;

   // ##############################
   // Sticky vector
   // ##############################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_error_vector <= '0;
      end else if (i_clear_errors) begin
         o_error_vector <= new_err;            // Fresh error still logs
      end else begin
         o_error_vector <= o_error_vector | new_err;
      end
   end

   // ##############################
   // Header of the first error
   // ##############################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_error_hdr <= '0;
      end else if (new_hit && !frozen) begin
         o_error_hdr <= i_hdr_raw;   // Kept across a clear
      end
   end

endmodule

//--- protocol_checker/tlp_rule_checker.sv
// Combinational header rule checks producing the per-packet error vector
`timescale 1ns/10ps

module tlp_rule_checker
   import afu_chk_pkg::*;
(
   input  hdr_info_t i_hdr,
   output err_vec_t  o_err
);

   logic len_zero;
   logic pld_over;
   logic rd_over;
   logic tag_over;

   // ##############################
   // Limit compares
   // ##############################
   assign len_zero = (i_hdr.length == '0);
   assign pld_over = (i_hdr.length > MAX_PLD_BYTES);
   assign rd_over  = (i_hdr.length > MAX_RD_REQ_BYTES);
   assign tag_over = (i_hdr.tag >= MAX_TAGS);

   // ##############################
   // Rules
   // ##############################
   always_comb begin
      o_err = '0;

      // Unknown fmt-type or empty packet
      o_err.malformed   = ~i_hdr.type_ok | len_zero;

      // Write payload above the max
      o_err.max_payload = i_hdr.is_wr & pld_over;

      // Read request above the max
      o_err.max_rd_req  = i_hdr.is_rd & rd_over;

      // Only reads consume a tag
      o_err.max_tag     = i_hdr.is_rd & tag_over;
   end

endmodule

//--- common/afu_chk_pkg.sv
// Shared widths, limits, fmt-type codes and the flit, header and error structs
package afu_chk_pkg;

   // ##############################
   // Widths
   // ##############################
   localparam int DATA_W = 256;
   localparam int KEEP_W = DATA_W / 8;       // One enable per byte
   localparam int HDR_W  = 128;              // Header overlay on the first beat
   localparam int TAG_W  = 10;
   localparam int LEN_W  = 24;               // Length in bytes

   // ##############################
   // Limits
   // ##############################
   localparam logic [LEN_W-1:0] MAX_PLD_BYTES    = 24'd512;
   localparam logic [LEN_W-1:0] MAX_RD_REQ_BYTES = 24'd1024;
   localparam logic [TAG_W-1:0] MAX_TAGS         = 10'd96;   // Legal tags are 0..95

   // Legal fmt-type codes, anything else is malformed
   localparam logic [7:0] FMT_MRD  = 8'h20;
   localparam logic [7:0] FMT_MWR  = 8'h60;
   localparam logic [7:0] FMT_CPLD = 8'h4A;

   // ##############################
   // Bus and header types
   // ##############################

   // One beat on the TX bus
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [KEEP_W-1:0] keep;
      logic              last;   // Final beat of the packet
   } tlp_flit_t;

   // Header as laid over data[HDR_W-1:0] of the SOP beat
   typedef struct packed {
      logic [7:0]       fmt_type;
      logic [LEN_W-1:0] length;
      logic [TAG_W-1:0] tag;
      logic [21:0]      rsvd;
      logic [63:0]      addr;
   } tlp_hdr_t;

   // Decoded header fields used by the rule checks
   typedef struct packed {
      logic             is_rd;
      logic             is_wr;
      logic             is_cpl;
      logic             type_ok;   // fmt_type is one of the legal codes
      logic [LEN_W-1:0] length;
      logic [TAG_W-1:0] tag;
   } hdr_info_t;

   // Per-packet and sticky error bits
   typedef struct packed {
      logic malformed;
      logic max_payload;
      logic max_rd_req;
      logic max_tag;
   } err_vec_t;

endpackage
